//--- filelist.f
rtl/sunsoft3_pkg.sv
rtl/sunsoft3_write_fsm.sv
rtl/sunsoft3_irq_timer.sv
rtl/sunsoft3_prg_map.sv
rtl/sunsoft3_chr_map.sv
rtl/sunsoft3_mapper.sv
+incdir+test
test/sunsoft3_tb.sv

//--- build.sh
#!/bin/sh
# Build and run the Sunsoft-3 mapper testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module sunsoft3_tb -f filelist.f -o sunsoft3_sim

# The log decides the result, so a fatal exit of the simulator must not stop the script here
./obj_dir/sunsoft3_sim 2>&1 | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "Simulation PASSED"
else
	echo "Simulation FAILED, see sim.log"
	exit 1
fi

//--- test/sunsoft3_tasks.svh
// Sunsoft-3 testbench tasks, bus write, compare, mapping models and directed tests
`ifndef SUNSOFT3_TASKS_SVH
`define SUNSOFT3_TASKS_SVH
`default_nettype none

// One CPU write cycle, ends on the falling edge after the write edge
task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
	@(negedge clk);
	ce        = 1'b1;
	prg_write = 1'b1;
	prg_ain   = addr;
	prg_din   = data;
	@(negedge clk);
	prg_write = 1'b0;   // Back to idle bus
	prg_ain   = '0;
endtask

task automatic expect_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("Error: %s is %h, expected %h", name, actual, expected);
		$display("tests failed");
		$fatal(1, "Mismatch on %s", name);
	end
endtask

// CHR: prefix 100, bank of the 2 kB window, offset in window
function automatic logic [31:0] chr_model(input logic [13:0] ain);
	logic [31:0] bank;
	bank = {24'b0, chr_exp[ain[12:11]]};
	return (32'd4 << 19) | (bank << 11) | {21'b0, ain[10:0]};
endfunction

// PRG: work RAM at $6000-$7FFF, else 6 bank bits over a 16 kB offset
function automatic logic [31:0] prg_model(input logic [15:0] ain);
	logic [31:0] bank;
	if (ain >= 16'h6000 && ain <= 16'h7fff)
		return (32'h1e0 << 13) | {19'b0, ain[12:0]};
	bank = ain[14] ? 32'h3f : {26'b0, prg_exp[5:0]};   // Upper half is the last bank
	return (bank << 14) | {18'b0, ain[13:0]};
endfunction

function automatic logic allow_model(input logic [15:0] ain, input logic wr);
	if (ain >= 16'h6000 && ain <= 16'h7fff)
		return 1'b1;        // RAM read and write
	return ain[15] & ~wr;   // ROM read only
endfunction

function automatic logic a10_model(input logic [1:0] mode, input logic [13:0] ain);
	case (mode)
		2'd0:    return ain[10];   // Vertical
		2'd1:    return ain[11];   // Horizontal
		2'd2:    return 1'b0;
		default: return 1'b1;
	endcase
endfunction

task automatic reset_state_test();
	for (int b = 0; b < 4; b++)
		chr_exp[b] = '0;
	prg_exp = '0;
	chr_ain = '0;
	prg_ain = 16'h8000;   // Read, no write strobe
	#settle;
	expect_equal("irq", 32'(irq), 32'd0);
	expect_equal("chr_aout", 32'(chr_aout), chr_model(chr_ain));
	expect_equal("prg_aout", 32'(prg_aout), prg_model(prg_ain));
	@(negedge clk);
	chr_ain = 14'h0400;   // A10 set, vertical gives 1
	#settle;
	expect_equal("vram_a10", 32'(vram_a10), 32'd1);
	@(negedge clk);
	chr_ain = 14'h0800;   // A11 only, vertical gives 0
	prg_ain = '0;
	#settle;
	expect_equal("vram_a10", 32'(vram_a10), 32'd0);
endtask

task automatic chr_banking_test();
	for (int i = 0; i < 4; i++) begin
		rnd = $random(seed);
		chr_exp[i] = rnd[7:0];
		cpu_write({1'b1, i[2:0], 1'b1, rnd[18:8]}, rnd[7:0]);   // Any low bits decode
	end
	for (int i = 0; i < 4; i++) begin
		rnd = $random(seed);
		cpu_write({1'b1, i[2:0], 1'b0, rnd[18:8]}, ~chr_exp[i]);   // A11 clear, ignored
	end
	for (int i = 0; i < sweep_n; i++) begin
		@(negedge clk);
		rnd = $random(seed);
		chr_ain = rnd[13:0];
		#settle;
		expect_equal("chr_aout", 32'(chr_aout), chr_model(chr_ain));
		expect_equal("vram_ce", 32'(vram_ce), 32'(rnd[13]));
	end
endtask

task automatic mirroring_test();
	for (int m = 0; m < 4; m++) begin
		rnd = $random(seed);
		cpu_write(16'he800, {rnd[7:2], m[1:0]});   // Upper data bits are don't care
		for (int p = 0; p < 4; p++) begin
			@(negedge clk);
			rnd = $random(seed);
			chr_ain = {rnd[13:12], p[1:0], rnd[9:0]};   // Walk A11..A10
			#settle;
			expect_equal("vram_a10", 32'(vram_a10), 32'(a10_model(m[1:0], chr_ain)));
		end
	end
endtask

task automatic prg_mapping_test();
	logic [15:0] addr;
	rnd = $random(seed);
	prg_exp = rnd[7:0];
	cpu_write(16'hf800, prg_exp);
	ce = 1'b0;   // Frozen, so write strobes during the sweep touch no register
	for (int i = 0; i < sweep_n; i++) begin
		@(negedge clk);
		rnd = $random(seed);
		addr = rnd[15:0];
		if (i < 16) begin
			case (i[3:1])   // Region edges, each read and written
				3'd0:    addr = 16'h6000;
				3'd1:    addr = 16'h7fff;
				3'd2:    addr = 16'h8000;
				3'd3:    addr = 16'hbfff;
				3'd4:    addr = 16'hc000;
				3'd5:    addr = 16'hffff;
				3'd6:    addr = 16'h5fff;
				default: addr = 16'h0000;
			endcase
		end
		prg_ain   = addr;
		prg_write = i[0];
		#settle;
		expect_equal("prg_aout", 32'(prg_aout), prg_model(addr));
		expect_equal("prg_allow", 32'(prg_allow), 32'(allow_model(addr, i[0])));
	end
	@(negedge clk);
	prg_write = 1'b0;
	prg_ain   = '0;
	ce        = 1'b1;
endtask

task automatic irq_timing_test();
	int n;
	rnd = $random(seed);
	n = {16'b0, rnd[15:0]} % max_count;
	cpu_write(16'hc800, n[15:8]);   // High byte first
	cpu_write(16'hc800, n[7:0]);
	cpu_write(16'hd800, 8'h10);     // Enable
	for (int k = 0; k < n; k++) begin
		@(negedge clk);
		expect_equal("irq", 32'(irq), 32'd0);
	end
	@(negedge clk);   // Edge N+1
	expect_equal("irq", 32'(irq), 32'd1);
	repeat (idle_cycles) begin
		@(negedge clk);
		expect_equal("irq", 32'(irq), 32'd1);   // Held until acknowledged
	end
endtask

task automatic irq_ack_order_test();
	int m;
	cpu_write(16'hd800, 8'h00);
	expect_equal("irq", 32'(irq), 32'd0);
	rnd = $random(seed);
	cpu_write(16'hc800, rnd[7:0]);   // Lone high byte
	cpu_write(16'hd800, 8'h00);      // Byte order back to high
	m = 288 + {27'b0, rnd[12:8]};    // Bytes differ, a swap would be obvious
	cpu_write(16'hc800, m[15:8]);
	cpu_write(16'hc800, m[7:0]);
	cpu_write(16'hd800, 8'h10);
	ce = 1'b0;
	repeat (frozen_cycles) begin
		@(negedge clk);
		expect_equal("irq", 32'(irq), 32'd0);
	end
	ce = 1'b1;   // Counting starts at the next edge
	for (int k = 0; k < m; k++) begin
		@(negedge clk);
		expect_equal("irq", 32'(irq), 32'd0);
	end
	@(negedge clk);
	expect_equal("irq", 32'(irq), 32'd1);
endtask

`default_nettype wire
`endif

//--- test/sunsoft3_tb.sv
// Sunsoft-3 mapper testbench top with clock, reset, DUT, watchdog and directed test sequence
`default_nettype none

module sunsoft3_tb;

	localparam int half_period   = 10;    // 20 unit clock
	localparam int settle        = 5;     // Combinational settle after a falling edge drive
	localparam int reset_cycles  = 4;
	localparam int write_cycles  = 2;     // Cost of one cpu_write
	localparam int sweep_n       = 128;   // Random addresses per sweep
	localparam int max_count     = 200;   // IRQ count upper bound, exclusive
	localparam int max_load      = 320;   // Largest count in the byte order test
	localparam int frozen_cycles = 50;    // Cycles with ce held low
	localparam int idle_cycles   = 20;    // irq hold check

	// Sum of the test lengths in clock cycles
	localparam int test_cycles = reset_cycles + 4             // Reset state
		+ 8 * write_cycles + sweep_n                          // CHR banking
		+ 4 * (write_cycles + 4)                              // Mirroring
		+ write_cycles + sweep_n + 1                          // PRG mapping
		+ 3 * write_cycles + max_count + 1 + idle_cycles      // IRQ timing
		+ 7 * write_cycles + frozen_cycles + max_load + 1;    // Ack and byte order
	localparam int timeout_cycles = 2 * test_cycles;          // Twice the expected length

	logic                                  clk = 1'b0;
	logic                                  reset;
	logic                                  ce;
	logic [sunsoft3_pkg::cpu_addr_w-1:0]  prg_ain;
	logic                                  prg_write;
	logic [sunsoft3_pkg::data_w-1:0]      prg_din;
	logic [sunsoft3_pkg::ppu_addr_w-1:0]  chr_ain;
	wire  [sunsoft3_pkg::out_addr_w-1:0]  prg_aout;
	wire                                   prg_allow;
	wire  [sunsoft3_pkg::out_addr_w-1:0]  chr_aout;
	wire                                   vram_a10;
	wire                                   vram_ce;
	wire                                   irq;

	int                                    cycle_count = 0;
	integer                                seed = 32'h1adb_55a2;   // Fixed random seed
	logic [31:0]                           rnd;                    // Last random draw
	logic [sunsoft3_pkg::bank_w-1:0]       chr_exp [4];            // Expected CHR banks
	logic [sunsoft3_pkg::bank_w-1:0]       prg_exp;                // Expected PRG bank

	always #half_period clk = ~clk;

	sunsoft3_mapper u_dut (
		.clk       (clk),
		.reset     (reset),
		.ce        (ce),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.chr_ain   (chr_ain),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce),
		.irq       (irq)
	);

	// Watchdog on rising edges
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("tests failed");
			$fatal(1, "Timeout: test sequence did not finish within %0d cycles", timeout_cycles);
		end
	end

	initial begin
		reset     = 1'b1;
		ce        = 1'b0;
		prg_ain   = '0;
		prg_write = 1'b0;
		prg_din   = '0;
		chr_ain   = '0;

		repeat (reset_cycles) @(negedge clk);   // Four rising edges in reset
		reset = 1'b0;
		ce    = 1'b1;                           // CPU clock runs every cycle

		reset_state_test();
		chr_banking_test();
		mirroring_test();
		prg_mapping_test();
		irq_timing_test();
		irq_ack_order_test();

		$display("all tests passed");
		$finish;
	end

	`include "sunsoft3_tasks.svh"

endmodule

`default_nettype wire

//--- rtl/sunsoft3_mapper.sv
// Sunsoft-3 (mapper 67) top, joins write decoder, IRQ timer and PRG/CHR mapping
`default_nettype none

module sunsoft3_mapper (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire                                  ce,          // CPU cycle enable
	input  wire  [sunsoft3_pkg::cpu_addr_w-1:0] prg_ain,
	input  wire                                  prg_write,
	input  wire  [sunsoft3_pkg::data_w-1:0]     prg_din,
	input  wire  [sunsoft3_pkg::ppu_addr_w-1:0] chr_ain,
	output wire  [sunsoft3_pkg::out_addr_w-1:0] prg_aout,
	output wire                                  prg_allow,
	output wire  [sunsoft3_pkg::out_addr_w-1:0] chr_aout,
	output wire                                  vram_a10,
	output wire                                  vram_ce,
	output wire                                  irq
);

	sunsoft3_pkg::reg_op_t            reg_op;     // Decoded register write
	wire [sunsoft3_pkg::data_w-1:0]   reg_data;   // Write data

	sunsoft3_write_fsm u_write_fsm (
		.clk       (clk),
		.reset     (reset),
		.ce        (ce),
		.prg_write (prg_write),
		.prg_ain   (prg_ain),
		.prg_din   (prg_din),
		.reg_op    (reg_op),
		.reg_data  (reg_data)
	);

	sunsoft3_irq_timer u_irq_timer (
		.clk      (clk),
		.reset    (reset),
		.ce       (ce),
		.reg_op   (reg_op),
		.reg_data (reg_data),
		.irq      (irq)
	);

	sunsoft3_prg_map u_prg_map (
		.clk       (clk),
		.reset     (reset),
		.ce        (ce),
		.reg_op    (reg_op),
		.reg_data  (reg_data),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow)
	);

	sunsoft3_chr_map u_chr_map (
		.clk      (clk),
		.reset    (reset),
		.ce       (ce),
		.reg_op   (reg_op),
		.reg_data (reg_data),
		.chr_ain  (chr_ain),
		.chr_aout (chr_aout),
		.vram_a10 (vram_a10),
		.vram_ce  (vram_ce)
	);

endmodule

`default_nettype wire

//--- rtl/sunsoft3_chr_map.sv
// Sunsoft-3 CHR mapping, four 2 kB banks plus nametable mirroring and VRAM select
`default_nettype none

module sunsoft3_chr_map (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire                                  ce,
	input  wire  sunsoft3_pkg::reg_op_t          reg_op,
	input  wire  [sunsoft3_pkg::data_w-1:0]     reg_data,
	input  wire  [sunsoft3_pkg::ppu_addr_w-1:0] chr_ain,
	output logic [sunsoft3_pkg::out_addr_w-1:0] chr_aout,
	output logic                                 vram_a10,   // Nametable A10
	output logic                                 vram_ce     // Internal VRAM select
);

	logic [sunsoft3_pkg::bank_w-1:0] chr_bank [4];   // One per 2 kB window
	logic [sunsoft3_pkg::bank_w-1:0] chr_sel;
	sunsoft3_pkg::mirror_t           mirroring;

	always_ff @(posedge clk) begin
		if (reset) begin
			chr_bank[0] <= '0;
			chr_bank[1] <= '0;
			chr_bank[2] <= '0;
			chr_bank[3] <= '0;
			mirroring   <= sunsoft3_pkg::mirror_vertical;
		end else if (ce) begin
			case (reg_op)
				sunsoft3_pkg::op_chr0:   chr_bank[0] <= reg_data;
				sunsoft3_pkg::op_chr1:   chr_bank[1] <= reg_data;
				sunsoft3_pkg::op_chr2:   chr_bank[2] <= reg_data;
				sunsoft3_pkg::op_chr3:   chr_bank[3] <= reg_data;
				sunsoft3_pkg::op_mirror: mirroring <= sunsoft3_pkg::mirror_t'(reg_data[1:0]);
				default: ;   // Other registers live elsewhere
			endcase
		end
	end

	assign chr_sel  = chr_bank[chr_ain[12:11]];   // PPU A12..A11 picks window
	assign chr_aout = {sunsoft3_pkg::chr_prefix, chr_sel, chr_ain[10:0]};

	always_comb begin
		case (mirroring)
			sunsoft3_pkg::mirror_vertical:    vram_a10 = chr_ain[10];
			sunsoft3_pkg::mirror_horizontal:  vram_a10 = chr_ain[11];
			sunsoft3_pkg::mirror_single_low:  vram_a10 = 1'b0;
			sunsoft3_pkg::mirror_single_high: vram_a10 = 1'b1;
			default:                          vram_a10 = chr_ain[10];
		endcase
	end

	assign vram_ce = chr_ain[13];   // $2000 and up is nametable space

endmodule

`default_nettype wire

//--- rtl/sunsoft3_prg_map.sv
// Sunsoft-3 PRG mapping, 16 kB switchable bank, fixed last bank and 8 kB work RAM
`default_nettype none

module sunsoft3_prg_map (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire                                  ce,
	input  wire  sunsoft3_pkg::reg_op_t          reg_op,
	input  wire  [sunsoft3_pkg::data_w-1:0]     reg_data,
	input  wire  [sunsoft3_pkg::cpu_addr_w-1:0] prg_ain,
	input  wire                                  prg_write,
	output logic [sunsoft3_pkg::out_addr_w-1:0] prg_aout,
	output logic                                 prg_allow
);

	logic [sunsoft3_pkg::bank_w-1:0] prg_bank;     // $8000-$BFFF bank
	logic [sunsoft3_pkg::bank_w-1:0] bank_sel;     // Bank for this access
	logic                            prg_is_ram;   // $6000-$7FFF

	always_ff @(posedge clk) begin
		if (reset)
			prg_bank <= '0;
		else if (ce && reg_op == sunsoft3_pkg::op_prg)
			prg_bank <= reg_data;   // Full byte kept, low bits used
	end

	assign prg_is_ram = (prg_ain[15:13] == 3'b011);

	// A14 picks switchable or hardwired last bank
	assign bank_sel = prg_ain[14] ? sunsoft3_pkg::prg_fixed_bank : prg_bank;

	always_comb begin
		if (prg_is_ram)
			prg_aout = {sunsoft3_pkg::prg_ram_prefix, prg_ain[12:0]};
		else
			prg_aout = {2'b00, bank_sel[sunsoft3_pkg::prg_bank_used_w-1:0], prg_ain[13:0]};
	end

	// ROM is read only, RAM takes both
	assign prg_allow = prg_is_ram | (prg_ain[15] & ~prg_write);

endmodule

`default_nettype wire

//--- rtl/sunsoft3_irq_timer.sv
// Sunsoft-3 IRQ timer, 16-bit CPU cycle down-counter with interrupt flag and acknowledge
`default_nettype none

module sunsoft3_irq_timer (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              ce,        // One count per CPU cycle
	input  wire sunsoft3_pkg::reg_op_t       reg_op,
	input  wire [sunsoft3_pkg::data_w-1:0]  reg_data,
	output logic                             irq
);

	logic [sunsoft3_pkg::timer_w-1:0] irq_counter;
	logic                             irq_enable;

	always_ff @(posedge clk) begin
		if (reset) begin
			irq_counter <= '0;
			irq_enable  <= 1'b0;
			irq         <= 1'b0;
		end else if (ce) begin
			// Byte loads win over the count in the same cycle
			if (reg_op == sunsoft3_pkg::op_irq_load_high) begin
				irq_counter <= {reg_data, irq_counter[7:0]};
			end else if (reg_op == sunsoft3_pkg::op_irq_load_low) begin
				irq_counter <= {irq_counter[15:8], reg_data};
			end else if (irq_enable) begin
				// Zero minus one wraps to FFFF as the chip does
				irq_counter <= irq_counter - sunsoft3_pkg::timer_w'(1);
				if (irq_counter == '0) begin
					irq        <= 1'b1;   // Underflow
					irq_enable <= 1'b0;   // One shot
				end
			end

			// Control write re-arms and acks, overriding an underflow this cycle
			if (reg_op == sunsoft3_pkg::op_irq_ctrl) begin
				irq_enable <= reg_data[4];
				irq        <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/sunsoft3_write_fsm.sv
// Sunsoft-3 CPU write decoder, turns register writes into opcodes and orders IRQ counter bytes
`default_nettype none

module sunsoft3_write_fsm (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire                                  ce,          // CPU cycle enable
	input  wire                                  prg_write,
	input  wire  [sunsoft3_pkg::cpu_addr_w-1:0] prg_ain,
	input  wire  [sunsoft3_pkg::data_w-1:0]     prg_din,
	output sunsoft3_pkg::reg_op_t                reg_op,
	output logic [sunsoft3_pkg::data_w-1:0]     reg_data
);

	sunsoft3_pkg::write_state_t state;   // Byte order for $C800
	logic                       wr_hit;  // Qualified register write

	// Register space is $8000-$FFFF with A11 set, one CPU cycle per write
	assign wr_hit = ce & prg_write & prg_ain[15] & prg_ain[11];

	assign reg_data = prg_din;   // Data goes straight to the register owners

	always_comb begin
		reg_op = sunsoft3_pkg::op_none;
		if (wr_hit) begin
			case (prg_ain[14:12])   // Register select in A14..A12
				3'd0: reg_op = sunsoft3_pkg::op_chr0;
				3'd1: reg_op = sunsoft3_pkg::op_chr1;
				3'd2: reg_op = sunsoft3_pkg::op_chr2;
				3'd3: reg_op = sunsoft3_pkg::op_chr3;
				3'd4: begin
					// Same address for both bytes, state picks which one
					if (state == sunsoft3_pkg::load_high)
						reg_op = sunsoft3_pkg::op_irq_load_high;
					else
						reg_op = sunsoft3_pkg::op_irq_load_low;
				end
				3'd5: reg_op = sunsoft3_pkg::op_irq_ctrl;
				3'd6: reg_op = sunsoft3_pkg::op_mirror;
				3'd7: reg_op = sunsoft3_pkg::op_prg;
				default: reg_op = sunsoft3_pkg::op_none;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sunsoft3_pkg::load_high;
		end else begin
			case (reg_op)
				sunsoft3_pkg::op_irq_load_high: state <= sunsoft3_pkg::load_low;    // Low byte next
				sunsoft3_pkg::op_irq_load_low:  state <= sunsoft3_pkg::load_high;   // Pair done
				sunsoft3_pkg::op_irq_ctrl:      state <= sunsoft3_pkg::load_high;   // Resync on ack
				default:                        state <= state;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/sunsoft3_pkg.sv
// Sunsoft-3 mapper shared widths, register opcodes, FSM states and mapping constants
`default_nettype none

package sunsoft3_pkg;

	localparam int cpu_addr_w      = 16;    // CPU address bus
	localparam int ppu_addr_w      = 14;    // PPU address bus
	localparam int out_addr_w      = 22;    // Translated ROM/RAM address
	localparam int data_w          = 8;     // CPU data bus
	localparam int bank_w          = 8;     // Stored bank register
	localparam int prg_bank_used_w = 6;     // PRG bank bits that reach the address
	localparam int timer_w         = 16;    // IRQ cycle counter

	// Register opcodes issued by the write decoder
	typedef enum logic [3:0] {
		op_none,            // No qualified write this cycle
		op_chr0,            // $8800 CHR bank at PPU $0000
		op_chr1,            // $9800 CHR bank at PPU $0800
		op_chr2,            // $A800 CHR bank at PPU $1000
		op_chr3,            // $B800 CHR bank at PPU $1800
		op_irq_load_high,   // $C800 first write, counter bits 15:8
		op_irq_load_low,    // $C800 second write, counter bits 7:0
		op_irq_ctrl,        // $D800 enable and acknowledge
		op_mirror,          // $E800 nametable mirroring
		op_prg              // $F800 16 kB bank at $8000
	} reg_op_t;

	// Which counter byte the next $C800 write loads
	typedef enum logic {
		load_high,
		load_low
	} write_state_t;

	// Mirroring modes, encoded as written to $E800 bits 1:0
	typedef enum logic [1:0] {
		mirror_vertical    = 2'b00,   // A10 from PPU A10
		mirror_horizontal  = 2'b01,   // A10 from PPU A11
		mirror_single_low  = 2'b10,   // Lower nametable only
		mirror_single_high = 2'b11    // Upper nametable only
	} mirror_t;

	localparam logic [8:0]        prg_ram_prefix = 9'b111100000;   // Work RAM region
	localparam logic [2:0]        chr_prefix     = 3'b100;         // CHR ROM region
	localparam logic [bank_w-1:0] prg_fixed_bank = '1;             // Last bank at $C000

endpackage

`default_nettype wire
